// File: rtl/tx_cfg_pkg.sv
`default_nettype none

package tx_cfg_pkg;

  // ------------------------------
  // transmit datapath
  // ------------------------------
  localparam int DATA_W = 64;                        // one beat on the tx port
  localparam int KEEP_W = DATA_W / 8;
  localparam int DW_W   = 32;

  localparam logic [KEEP_W-1:0] KEEP_ALL = 8'hFF;
  localparam logic [KEEP_W-1:0] KEEP_LO  = 8'h0F;    // dword 0 only

  // ------------------------------
  // dma write burst
  // ------------------------------
  localparam int WR_BURST_BYTES = 128;
  localparam int WR_BURST_DW    = WR_BURST_BYTES / 4;
  localparam int WR_BURST_WORDS = WR_BURST_BYTES / (DATA_W / 8);
  localparam int WR_BURST_BEATS = WR_BURST_WORDS + 2; // header, addr shift
  localparam int WR_CNT_W       = $clog2(WR_BURST_BEATS);

  // owner of the tx port
  typedef enum logic [2:0] {
    SRC_NONE,
    SRC_CPL,
    SRC_RD,
    SRC_WR,
    SRC_INTR
  } tx_src_e;

endpackage

`default_nettype wire

// File: rtl/tlp_pkg.sv
`default_nettype none

package tlp_pkg;

  // ------------------------------
  // fmt/type codes, 3dw headers
  // ------------------------------
  localparam logic [6:0] FT_CPLD = 7'h4A;
  localparam logic [6:0] FT_MRD  = 7'h00;
  localparam logic [6:0] FT_MWR  = 7'h40;

  // ------------------------------
  // header fields
  // ------------------------------
  localparam int LEN_W     = 10;                     // length in dwords
  localparam int TAG_W     = 8;
  localparam int ID_W      = 16;                     // bus/dev/func
  localparam int BCNT_W    = 12;                     // byte count
  localparam int LOWADDR_W = 7;

  localparam logic [7:0]        BE_ALL        = 8'hFF;  // last and first BE
  localparam logic [2:0]        CPL_STATUS_SC = 3'b000; // successful completion
  localparam logic [BCNT_W-1:0] CPL_BYTE_CNT  = 12'd4;

  // common first header dword
  function automatic logic [31:0] tlp_dw0(
    input logic [6:0]       ft,
    input logic [2:0]       tc,
    input logic             td,
    input logic             ep,
    input logic [1:0]       attr,
    input logic [LEN_W-1:0] len
  );
    return {1'b0, ft, 1'b0, tc, 4'b0000, td, ep, attr, 2'b00, len};
  endfunction

  // second dword of a memory request
  function automatic logic [31:0] tlp_req_dw1(
    input logic [ID_W-1:0]  req_id,
    input logic [TAG_W-1:0] tag
  );
    return {req_id, tag, BE_ALL};
  endfunction

endpackage

`default_nettype wire

// File: rtl/tx_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module tx_arbiter (
  input  wire                 clk_i,
  input  wire                 rst_n,
  input  wire                 cpl_req_valid_i,
  input  wire                 rd_req_valid_i,
  input  wire                 wr_fifo_avail_i,
  input  wire                 intr_req_i,
  input  wire                 pkt_done_i,
  output tx_cfg_pkg::tx_src_e grant_o
);

  import tx_cfg_pkg::*;

  tx_src_e next_src;
  logic    intr_hold;                                // intr done still visible to source

  // ------------------------------
  // fixed priority pick
  // ------------------------------
  always_comb
  begin
    if (cpl_req_valid_i)
    begin
      next_src = SRC_CPL;
    end
    else if (rd_req_valid_i)
    begin
      next_src = SRC_RD;
    end
    else if (wr_fifo_avail_i)
    begin
      next_src = SRC_WR;                             // full burst waiting
    end
    else if (intr_req_i && !intr_hold)
    begin
      next_src = SRC_INTR;
    end
    else
    begin
      next_src = SRC_NONE;
    end
  end

  // ------------------------------
  // grant register
  // ------------------------------
  always_ff @(posedge clk_i)
  begin
    if (!rst_n)
    begin
      grant_o   <= SRC_NONE;
      intr_hold <= 1'b0;
    end
    else
    begin
      intr_hold <= pkt_done_i && (grant_o == SRC_INTR);
      if (grant_o != SRC_NONE)
      begin
        if (pkt_done_i)
        begin
          grant_o <= SRC_NONE;                       // one idle cycle between packets
        end
      end
      else
      begin
        grant_o <= next_src;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/tlp_short_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tlp_short_gen (
  input  wire                                clk_i,
  input  wire                                rst_n,
  input  wire tx_cfg_pkg::tx_src_e           grant_i,
  input  wire [2:0]                          cpl_tc_i,
  input  wire                                cpl_td_i,
  input  wire                                cpl_ep_i,
  input  wire [1:0]                          cpl_attr_i,
  input  wire [tlp_pkg::LEN_W-1:0]           cpl_len_i,
  input  wire [tlp_pkg::ID_W-1:0]            cpl_rid_i,
  input  wire [tlp_pkg::TAG_W-1:0]           cpl_tag_i,
  input  wire [tlp_pkg::LOWADDR_W-1:0]       cpl_lower_addr_i,
  input  wire [tx_cfg_pkg::DW_W-1:0]         reg_data_i,
  input  wire [tx_cfg_pkg::DW_W-1:0]         rd_req_addr_i,
  input  wire [tlp_pkg::BCNT_W-1:0]          rd_req_len_i,
  input  wire [tlp_pkg::TAG_W-1:0]           rd_req_tag_i,
  input  wire [tlp_pkg::ID_W-1:0]            completer_id_i,
  input  wire                                beat_ready_i,
  output logic                               beat_valid_o,
  output logic [tx_cfg_pkg::DATA_W-1:0]      beat_data_o,
  output logic [tx_cfg_pkg::KEEP_W-1:0]      beat_keep_o,
  output logic                               beat_last_o,
  output logic                               cpl_req_ready_o,
  output logic                               rd_req_ready_o,
  output logic                               done_o
);

  import tx_cfg_pkg::*;
  import tlp_pkg::*;

  logic beat_idx;                                    // 0 header, 1 tail
  logic is_cpl;
  logic xfer;

  assign is_cpl          = (grant_i == SRC_CPL);
  assign beat_valid_o    = is_cpl || (grant_i == SRC_RD);
  assign xfer            = beat_valid_o && beat_ready_i;
  assign beat_last_o     = beat_idx;
  assign done_o          = xfer && beat_idx;
  assign cpl_req_ready_o = done_o && is_cpl;
  assign rd_req_ready_o  = done_o && !is_cpl;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n)
    begin
      beat_idx <= 1'b0;
    end
    else if (xfer)
    begin
      beat_idx <= !beat_idx;                         // wraps after the tail
    end
  end

  always_comb
  begin
    beat_keep_o = KEEP_ALL;
    if (is_cpl)
    begin
      if (!beat_idx)
      begin
        beat_data_o = {completer_id_i, CPL_STATUS_SC, 1'b0, CPL_BYTE_CNT,
                       tlp_dw0(FT_CPLD, cpl_tc_i, cpl_td_i, cpl_ep_i, cpl_attr_i, cpl_len_i)};
      end
      else
      begin
        beat_data_o = {reg_data_i, cpl_rid_i, cpl_tag_i, 1'b0, cpl_lower_addr_i};
      end
    end
    else if (!beat_idx)
    begin
      beat_data_o = {tlp_req_dw1(completer_id_i, rd_req_tag_i),
                     tlp_dw0(FT_MRD, 3'b000, 1'b0, 1'b0, 2'b00, rd_req_len_i[BCNT_W-1:2])};
    end
    else
    begin
      beat_data_o = {{DW_W{1'b0}}, rd_req_addr_i};   // 32-bit address only
      beat_keep_o = KEEP_LO;
    end
  end

endmodule

`default_nettype wire

// File: rtl/wr_burst_packer.sv
`timescale 1ns/100ps
`default_nettype none

module wr_burst_packer (
  input  wire                            clk_i,
  input  wire                            rst_n,
  input  wire tx_cfg_pkg::tx_src_e       grant_i,
  input  wire [tlp_pkg::ID_W-1:0]        completer_id_i,
  input  wire                            wr_addr_load_i,
  input  wire [tx_cfg_pkg::DW_W-1:0]     wr_base_addr_i,
  input  wire [tx_cfg_pkg::DATA_W-1:0]   wr_fifo_data_i,
  output logic                           wr_fifo_pop_o,
  input  wire                            beat_ready_i,
  output logic                           beat_valid_o,
  output logic [tx_cfg_pkg::DATA_W-1:0]  beat_data_o,
  output logic [tx_cfg_pkg::KEEP_W-1:0]  beat_keep_o,
  output logic                           beat_last_o,
  output logic                           done_o
);

  import tx_cfg_pkg::*;
  import tlp_pkg::*;

  logic [WR_CNT_W-1:0] beat_cnt;
  logic [DW_W-1:0]     addr_q;                       // system memory address
  logic [DW_W-1:0]     hi_q;                         // upper dword of the last popped word
  logic                xfer;
  logic                word_beat;

  assign beat_valid_o  = (grant_i == SRC_WR);
  assign xfer          = beat_valid_o && beat_ready_i;
  assign beat_last_o   = (beat_cnt == WR_CNT_W'(WR_BURST_BEATS - 1));
  assign word_beat     = (beat_cnt != '0) && !beat_last_o; // beats 1..16
  assign wr_fifo_pop_o = xfer && word_beat;
  assign done_o        = xfer && beat_last_o;

  // ------------------------------
  // beat counter
  // ------------------------------
  always_ff @(posedge clk_i)
  begin
    if (!rst_n)
    begin
      beat_cnt <= '0;
    end
    else if (xfer)
    begin
      beat_cnt <= beat_last_o ? '0 : beat_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (wr_addr_load_i)
    begin
      addr_q <= wr_base_addr_i;
    end
    else if (done_o)
    begin
      addr_q <= addr_q + DW_W'(WR_BURST_BYTES);      // next 128 byte block
    end
    if (wr_fifo_pop_o)
    begin
      hi_q <= wr_fifo_data_i[DATA_W-1:DW_W];
    end
  end

  // ------------------------------
  // dword realignment
  // ------------------------------
  always_comb
  begin
    beat_keep_o = KEEP_ALL;
    if (beat_cnt == '0)
    begin
      beat_data_o = {tlp_req_dw1(completer_id_i, {TAG_W{1'b0}}),
                     tlp_dw0(FT_MWR, 3'b000, 1'b0, 1'b0, 2'b00, LEN_W'(WR_BURST_DW))};
    end
    else if (beat_cnt == WR_CNT_W'(1))
    begin
      beat_data_o = {wr_fifo_data_i[DW_W-1:0], addr_q};  // addr sits in dword 2 of the header
    end
    else if (beat_last_o)
    begin
      beat_data_o = {{DW_W{1'b0}}, hi_q};
      beat_keep_o = KEEP_LO;
    end
    else
    begin
      beat_data_o = {wr_fifo_data_i[DW_W-1:0], hi_q};
    end
  end

endmodule

`default_nettype wire

// File: rtl/intr_sender.sv
`timescale 1ns/100ps
`default_nettype none

module intr_sender (
  input  wire                      clk_i,
  input  wire                      rst_n,
  input  wire tx_cfg_pkg::tx_src_e grant_i,
  input  wire                      cfg_interrupt_rdy_i,
  output logic                     cfg_interrupt_o,
  output logic                     intr_done_o,
  output logic                     done_o
);

  import tx_cfg_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT_RDY,
    ST_DONE
  } intr_state_e;

  intr_state_e state;

  assign cfg_interrupt_o = (state == ST_WAIT_RDY);
  assign intr_done_o     = (state == ST_DONE);
  assign done_o          = intr_done_o;              // also frees the arbiter

  always_ff @(posedge clk_i)
  begin
    if (!rst_n)
    begin
      state <= ST_IDLE;
    end
    else
    begin
      case (state)
        ST_IDLE:     if (grant_i == SRC_INTR) state <= ST_WAIT_RDY;
        ST_WAIT_RDY: if (cfg_interrupt_rdy_i) state <= ST_DONE;
        default:     state <= ST_IDLE;               // grant drops on this edge
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rtl/tx_out_stage.sv
`timescale 1ns/100ps
`default_nettype none

module tx_out_stage (
  input  wire                            clk_i,
  input  wire                            rst_n,
  input  wire tx_cfg_pkg::tx_src_e       grant_i,
  input  wire                            short_valid_i,
  input  wire [tx_cfg_pkg::DATA_W-1:0]   short_data_i,
  input  wire [tx_cfg_pkg::KEEP_W-1:0]   short_keep_i,
  input  wire                            short_last_i,
  input  wire                            wr_valid_i,
  input  wire [tx_cfg_pkg::DATA_W-1:0]   wr_data_i,
  input  wire [tx_cfg_pkg::KEEP_W-1:0]   wr_keep_i,
  input  wire                            wr_last_i,
  input  wire                            s_axis_tx_tready_i,
  output logic                           beat_ready_o,
  output logic [tx_cfg_pkg::DATA_W-1:0]  s_axis_tx_tdata_o,
  output logic [tx_cfg_pkg::KEEP_W-1:0]  s_axis_tx_tkeep_o,
  output logic                           s_axis_tx_tlast_o,
  output logic                           s_axis_tx_tvalid_o
);

  import tx_cfg_pkg::*;

  logic              sel_valid;
  logic [DATA_W-1:0] sel_data;
  logic [KEEP_W-1:0] sel_keep;
  logic              sel_last;

  always_comb
  begin
    case (grant_i)
      SRC_CPL, SRC_RD:
      begin
        sel_valid = short_valid_i;
        sel_data  = short_data_i;
        sel_keep  = short_keep_i;
        sel_last  = short_last_i;
      end
      SRC_WR:
      begin
        sel_valid = wr_valid_i;
        sel_data  = wr_data_i;
        sel_keep  = wr_keep_i;
        sel_last  = wr_last_i;
      end
      default:
      begin
        sel_valid = 1'b0;                            // interrupt has no beats
        sel_data  = '0;
        sel_keep  = '0;
        sel_last  = 1'b0;
      end
    endcase
  end

  // register empty or being drained
  assign beat_ready_o = !s_axis_tx_tvalid_o || s_axis_tx_tready_i;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n)
    begin
      s_axis_tx_tvalid_o <= 1'b0;
      s_axis_tx_tlast_o  <= 1'b0;
    end
    else if (beat_ready_o)
    begin
      s_axis_tx_tvalid_o <= sel_valid;
      s_axis_tx_tlast_o  <= sel_valid && sel_last;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (beat_ready_o && sel_valid)
    begin
      s_axis_tx_tdata_o <= sel_data;
      s_axis_tx_tkeep_o <= sel_keep;
    end
  end

endmodule

`default_nettype wire

// File: rtl/pcie_tx_top.sv
`timescale 1ns/100ps
`default_nettype none

module pcie_tx_top (
  input  wire                            clk_i,
  input  wire                            rst_n,
  input  wire [tlp_pkg::ID_W-1:0]        completer_id_i,
  // completion request
  input  wire                            cpl_req_valid_i,
  output logic                           cpl_req_ready_o,
  input  wire [2:0]                      cpl_tc_i,
  input  wire                            cpl_td_i,
  input  wire                            cpl_ep_i,
  input  wire [1:0]                      cpl_attr_i,
  input  wire [tlp_pkg::LEN_W-1:0]       cpl_len_i,
  input  wire [tlp_pkg::ID_W-1:0]        cpl_rid_i,
  input  wire [tlp_pkg::TAG_W-1:0]       cpl_tag_i,
  input  wire [tlp_pkg::LOWADDR_W-1:0]   cpl_lower_addr_i,
  input  wire [tx_cfg_pkg::DW_W-1:0]     reg_data_i,
  // dma read request
  input  wire                            rd_req_valid_i,
  output logic                           rd_req_ready_o,
  input  wire [tx_cfg_pkg::DW_W-1:0]     rd_req_addr_i,
  input  wire [tlp_pkg::BCNT_W-1:0]      rd_req_len_i,
  input  wire [tlp_pkg::TAG_W-1:0]       rd_req_tag_i,
  // dma write fifo
  input  wire                            wr_fifo_avail_i,
  input  wire [tx_cfg_pkg::DATA_W-1:0]   wr_fifo_data_i,
  output logic                           wr_fifo_pop_o,
  input  wire                            wr_addr_load_i,
  input  wire [tx_cfg_pkg::DW_W-1:0]     wr_base_addr_i,
  // interrupt
  input  wire                            intr_req_i,
  output logic                           intr_done_o,
  output logic                           cfg_interrupt_o,
  input  wire                            cfg_interrupt_rdy_i,
  // axi-stream tx
  input  wire                            s_axis_tx_tready_i,
  output logic [tx_cfg_pkg::DATA_W-1:0]  s_axis_tx_tdata_o,
  output logic [tx_cfg_pkg::KEEP_W-1:0]  s_axis_tx_tkeep_o,
  output logic                           s_axis_tx_tlast_o,
  output logic                           s_axis_tx_tvalid_o
);

  import tx_cfg_pkg::*;

  tx_src_e           grant;
  logic              beat_ready;
  logic              short_valid, short_last, short_done;
  logic [DATA_W-1:0] short_data;
  logic [KEEP_W-1:0] short_keep;
  logic              wr_valid, wr_last, wr_done;
  logic [DATA_W-1:0] wr_data;
  logic [KEEP_W-1:0] wr_keep;
  logic              intr_done;

  tx_arbiter tx_arbiter_inst (
    .clk_i(clk_i), .rst_n(rst_n),
    .cpl_req_valid_i(cpl_req_valid_i), .rd_req_valid_i(rd_req_valid_i),
    .wr_fifo_avail_i(wr_fifo_avail_i), .intr_req_i(intr_req_i),
    .pkt_done_i(short_done | wr_done | intr_done), .grant_o(grant)
  );

  tlp_short_gen tlp_short_gen_inst (
    .clk_i(clk_i), .rst_n(rst_n), .grant_i(grant),
    .cpl_tc_i(cpl_tc_i), .cpl_td_i(cpl_td_i), .cpl_ep_i(cpl_ep_i), .cpl_attr_i(cpl_attr_i),
    .cpl_len_i(cpl_len_i), .cpl_rid_i(cpl_rid_i), .cpl_tag_i(cpl_tag_i),
    .cpl_lower_addr_i(cpl_lower_addr_i), .reg_data_i(reg_data_i),
    .rd_req_addr_i(rd_req_addr_i), .rd_req_len_i(rd_req_len_i), .rd_req_tag_i(rd_req_tag_i),
    .completer_id_i(completer_id_i), .beat_ready_i(beat_ready),
    .beat_valid_o(short_valid), .beat_data_o(short_data), .beat_keep_o(short_keep),
    .beat_last_o(short_last), .cpl_req_ready_o(cpl_req_ready_o),
    .rd_req_ready_o(rd_req_ready_o), .done_o(short_done)
  );

  wr_burst_packer wr_burst_packer_inst (
    .clk_i(clk_i), .rst_n(rst_n), .grant_i(grant), .completer_id_i(completer_id_i),
    .wr_addr_load_i(wr_addr_load_i), .wr_base_addr_i(wr_base_addr_i),
    .wr_fifo_data_i(wr_fifo_data_i), .wr_fifo_pop_o(wr_fifo_pop_o),
    .beat_ready_i(beat_ready), .beat_valid_o(wr_valid), .beat_data_o(wr_data),
    .beat_keep_o(wr_keep), .beat_last_o(wr_last), .done_o(wr_done)
  );

  intr_sender intr_sender_inst (
    .clk_i(clk_i), .rst_n(rst_n), .grant_i(grant), .cfg_interrupt_rdy_i(cfg_interrupt_rdy_i),
    .cfg_interrupt_o(cfg_interrupt_o), .intr_done_o(intr_done_o), .done_o(intr_done)
  );

  tx_out_stage tx_out_stage_inst (
    .clk_i(clk_i), .rst_n(rst_n), .grant_i(grant),
    .short_valid_i(short_valid), .short_data_i(short_data),
    .short_keep_i(short_keep), .short_last_i(short_last),
    .wr_valid_i(wr_valid), .wr_data_i(wr_data), .wr_keep_i(wr_keep), .wr_last_i(wr_last),
    .s_axis_tx_tready_i(s_axis_tx_tready_i), .beat_ready_o(beat_ready),
    .s_axis_tx_tdata_o(s_axis_tx_tdata_o), .s_axis_tx_tkeep_o(s_axis_tx_tkeep_o),
    .s_axis_tx_tlast_o(s_axis_tx_tlast_o), .s_axis_tx_tvalid_o(s_axis_tx_tvalid_o)
  );

endmodule

`default_nettype wire

// File: sim/pcie_tx_tb.sv
`timescale 1ns/100ps
`default_nettype none

module pcie_tx_tb;

  localparam int FIFO_DEPTH = 32;

  logic        clk_i, rst_n;
  logic [15:0] completer_id;
  logic        cpl_req_valid_i, cpl_req_ready_o, cpl_td_i, cpl_ep_i;
  logic [2:0]  cpl_tc_i;
  logic [1:0]  cpl_attr_i;
  logic [9:0]  cpl_len_i;
  logic [15:0] cpl_rid_i;
  logic [7:0]  cpl_tag_i, rd_req_tag_i;
  logic [6:0]  cpl_lower_addr_i;
  logic [31:0] reg_data_i, rd_req_addr_i, wr_base_addr_i;
  logic        rd_req_valid_i, rd_req_ready_o;
  logic [11:0] rd_req_len_i;
  logic        wr_fifo_avail_i, wr_fifo_pop_o, wr_addr_load_i;
  logic [63:0] wr_fifo_data_i, s_axis_tx_tdata_o;
  logic        intr_req_i, intr_done_o, cfg_interrupt_o, cfg_interrupt_rdy_i;
  logic        s_axis_tx_tready_i, s_axis_tx_tlast_o, s_axis_tx_tvalid_o;
  logic [7:0]  s_axis_tx_tkeep_o;

  logic [72:0] exp_q[$];                             // {last, keep, data}
  logic [72:0] exp_beat;
  logic [63:0] fifo_mem [FIFO_DEPTH];
  int          pop_cnt, cpl_ready_cnt, rd_ready_cnt, intr_done_cnt, stall_cnt;
  logic        rand_ready, wr_enable;
  logic        cpl_ready_seen, rd_ready_seen, intr_done_seen;
  logic        prev_valid, prev_ready, prev_last, prev_intr, prev_intr_rdy;
  logic [63:0] prev_data;
  logic [7:0]  prev_keep;
  integer      seed;

  pcie_tx_top pcie_tx_top_inst (
    .clk_i(clk_i), .rst_n(rst_n), .completer_id_i(completer_id),
    .cpl_req_valid_i(cpl_req_valid_i), .cpl_req_ready_o(cpl_req_ready_o),
    .cpl_tc_i(cpl_tc_i), .cpl_td_i(cpl_td_i), .cpl_ep_i(cpl_ep_i), .cpl_attr_i(cpl_attr_i),
    .cpl_len_i(cpl_len_i), .cpl_rid_i(cpl_rid_i), .cpl_tag_i(cpl_tag_i),
    .cpl_lower_addr_i(cpl_lower_addr_i), .reg_data_i(reg_data_i),
    .rd_req_valid_i(rd_req_valid_i), .rd_req_ready_o(rd_req_ready_o),
    .rd_req_addr_i(rd_req_addr_i), .rd_req_len_i(rd_req_len_i), .rd_req_tag_i(rd_req_tag_i),
    .wr_fifo_avail_i(wr_fifo_avail_i), .wr_fifo_data_i(wr_fifo_data_i),
    .wr_fifo_pop_o(wr_fifo_pop_o), .wr_addr_load_i(wr_addr_load_i),
    .wr_base_addr_i(wr_base_addr_i), .intr_req_i(intr_req_i), .intr_done_o(intr_done_o),
    .cfg_interrupt_o(cfg_interrupt_o), .cfg_interrupt_rdy_i(cfg_interrupt_rdy_i),
    .s_axis_tx_tready_i(s_axis_tx_tready_i), .s_axis_tx_tdata_o(s_axis_tx_tdata_o),
    .s_axis_tx_tkeep_o(s_axis_tx_tkeep_o), .s_axis_tx_tlast_o(s_axis_tx_tlast_o),
    .s_axis_tx_tvalid_o(s_axis_tx_tvalid_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_true(input logic cond, input string msg);
    assert (cond) else stop_with_error(msg);
  endtask

  task automatic compare_hex(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp)
    else stop_with_error($sformatf("FAILED %s got %h expected %h", name, got, exp));
  endtask

  function automatic logic [63:0] byte_mask(input logic [7:0] keep);
    logic [63:0] m;
    for (int b = 0; b < 8; b++)
      m[8*b +: 8] = {8{keep[b]}};
    return m;
  endfunction

  task automatic push_beat(input logic [63:0] data, input logic [7:0] keep, input logic last);
    exp_q.push_back({last, keep, data});
  endtask

  // ------------------------------
  // sources and expected packets
  // ------------------------------
  task automatic send_completion(input logic [2:0] tc, input logic td, input logic ep,
                                 input logic [1:0] attr, input logic [9:0] len,
                                 input logic [15:0] rid, input logic [7:0] tag,
                                 input logic [6:0] laddr, input logic [31:0] data);
    cpl_tc_i         = tc;
    cpl_td_i         = td;
    cpl_ep_i         = ep;
    cpl_attr_i       = attr;
    cpl_len_i        = len;
    cpl_rid_i        = rid;
    cpl_tag_i        = tag;
    cpl_lower_addr_i = laddr;
    reg_data_i       = data;
    cpl_req_valid_i  = 1'b1;
    push_beat({completer_id, 3'b000, 1'b0, 12'd4,                      // status sc, 4 bytes
               1'b0, 7'h4A, 1'b0, tc, 4'b0000, td, ep, attr, 2'b00, len}, 8'hFF, 1'b0);
    push_beat({data, rid, tag, 1'b0, laddr}, 8'hFF, 1'b1);
  endtask

  task automatic send_read(input logic [31:0] addr, input logic [11:0] bytes,
                           input logic [7:0] tag);
    rd_req_addr_i  = addr;
    rd_req_len_i   = bytes;
    rd_req_tag_i   = tag;
    rd_req_valid_i = 1'b1;
    push_beat({completer_id, tag, 8'hFF,
               1'b0, 7'h00, 1'b0, 3'b000, 4'b0000, 4'b0000, 2'b00, 10'(bytes / 4)},
              8'hFF, 1'b0);
    push_beat({32'h0, addr}, 8'h0F, 1'b1);
  endtask

  task automatic expect_write_burst(input logic [31:0] addr, input int first);
    logic [63:0] w [16];
    for (int k = 0; k < 16; k++)
      w[k] = fifo_mem[(first + k) % FIFO_DEPTH];
    push_beat({completer_id, 8'h00, 8'hFF,
               1'b0, 7'h40, 1'b0, 3'b000, 4'b0000, 4'b0000, 2'b00, 10'd32}, 8'hFF, 1'b0);
    push_beat({w[0][31:0], addr}, 8'hFF, 1'b0);
    for (int n = 2; n < 17; n++)
      push_beat({w[n-1][31:0], w[n-2][63:32]}, 8'hFF, 1'b0);
    push_beat({32'h0, w[15][63:32]}, 8'h0F, 1'b1);    // tail dword only
  endtask

  task automatic wait_for_idle(input int max_cycles, input string what);
    int n;
    n = 0;
    while (exp_q.size() != 0)
    begin
      check_true(n < max_cycles, {"timeout while waiting for ", what});
      @(posedge clk_i);
      n++;
    end
    #1;
  endtask

  task automatic wait_intr_handshake(input int max_cycles);
    int n;
    n = 0;
    while (intr_done_cnt == 0)
    begin
      check_true(n < max_cycles, "timeout while waiting for the interrupt handshake");
      @(posedge clk_i);
      n++;
    end
    #1;
  endtask

  // inputs change 1 ns after the edge
  always @(posedge clk_i)
  begin
    #1;
    s_axis_tx_tready_i  = rand_ready ? (($random(seed) & 3) != 0) : 1'b1;
    cfg_interrupt_rdy_i = (($random(seed) & 3) == 0);
    wr_fifo_data_i      = fifo_mem[pop_cnt % FIFO_DEPTH]; // first word fall through
    wr_fifo_avail_i     = wr_enable && (FIFO_DEPTH - pop_cnt >= 16);
    if (cpl_ready_seen)
      cpl_req_valid_i = 1'b0;
    if (rd_ready_seen)
      rd_req_valid_i = 1'b0;
    if (intr_done_seen)
      intr_req_i = 1'b0;
  end

  // ------------------------------
  // port monitor
  // ------------------------------
  always @(negedge clk_i)
  begin
    if (!rst_n)
    begin
      prev_valid     = 1'b0;
      prev_ready     = 1'b0;
      prev_intr      = 1'b0;
      prev_intr_rdy  = 1'b0;
      cpl_ready_seen = 1'b0;
      rd_ready_seen  = 1'b0;
      intr_done_seen = 1'b0;
    end
    else
    begin
      if (prev_valid && !prev_ready)
      begin
        check_true(s_axis_tx_tvalid_o === 1'b1, "tvalid dropped while tready was low");
        compare_hex("s_axis_tx_tdata_o (held)", s_axis_tx_tdata_o, prev_data);
        compare_hex("s_axis_tx_tkeep_o (held)", s_axis_tx_tkeep_o, prev_keep);
        compare_hex("s_axis_tx_tlast_o (held)", s_axis_tx_tlast_o, prev_last);
      end
      if (s_axis_tx_tvalid_o && s_axis_tx_tready_i)
      begin
        check_true(exp_q.size() > 0, "a beat was sent while no packet was expected");
        exp_beat = exp_q.pop_front();
        compare_hex("s_axis_tx_tdata_o", s_axis_tx_tdata_o & byte_mask(exp_beat[71:64]),
                    exp_beat[63:0] & byte_mask(exp_beat[71:64]));
        compare_hex("s_axis_tx_tkeep_o", s_axis_tx_tkeep_o, exp_beat[71:64]);
        compare_hex("s_axis_tx_tlast_o", s_axis_tx_tlast_o, exp_beat[72]);
      end
      if (s_axis_tx_tvalid_o && !s_axis_tx_tready_i)
        stall_cnt++;
      if (wr_fifo_pop_o)
        pop_cnt++;
      if (cpl_req_ready_o)
        cpl_ready_cnt++;
      if (rd_req_ready_o)
        rd_ready_cnt++;
      cpl_ready_seen = cpl_req_ready_o;
      rd_ready_seen  = rd_req_ready_o;
      intr_done_seen = intr_done_o;

      // interrupt handshake
      if (!prev_intr && cfg_interrupt_o)
        check_true(exp_q.size() == 0 && !s_axis_tx_tvalid_o,
                   "cfg_interrupt_o rose while a packet was still in flight");
      if (prev_intr && !prev_intr_rdy)
        compare_hex("cfg_interrupt_o", cfg_interrupt_o, 1);
      if (prev_intr && prev_intr_rdy)
      begin
        compare_hex("intr_done_o", intr_done_o, 1);
        compare_hex("cfg_interrupt_o", cfg_interrupt_o, 0);
      end
      if (intr_done_o)
      begin
        check_true(prev_intr && prev_intr_rdy, "intr_done_o pulsed without a handshake");
        intr_done_cnt++;
      end

      prev_valid    = s_axis_tx_tvalid_o;
      prev_ready    = s_axis_tx_tready_i;
      prev_data     = s_axis_tx_tdata_o;
      prev_keep     = s_axis_tx_tkeep_o;
      prev_last     = s_axis_tx_tlast_o;
      prev_intr     = cfg_interrupt_o;
      prev_intr_rdy = cfg_interrupt_rdy_i;
    end
  end

  initial
  begin
    seed = 32'h2657;
    for (int i = 0; i < FIFO_DEPTH; i++)
      fifo_mem[i] = {32'h1000_0000 + 32'(2*i + 1), 32'h1000_0000 + 32'(2*i)};
    {pop_cnt, cpl_ready_cnt, rd_ready_cnt, intr_done_cnt, stall_cnt} = '0;
    rst_n = 1'b0;
    rand_ready = 1'b1;
    wr_enable = 1'b0;
    completer_id = 16'h0A10;
    {cpl_req_valid_i, cpl_td_i, cpl_ep_i, cpl_tc_i, cpl_attr_i, cpl_len_i} = '0;
    {cpl_rid_i, cpl_tag_i, cpl_lower_addr_i, reg_data_i} = '0;
    {rd_req_valid_i, rd_req_addr_i, rd_req_len_i, rd_req_tag_i} = '0;
    {wr_fifo_avail_i, wr_addr_load_i, wr_base_addr_i} = '0;
    wr_fifo_data_i = fifo_mem[0];
    {intr_req_i, cfg_interrupt_rdy_i} = '0;
    s_axis_tx_tready_i = 1'b1;
    repeat (10) @(posedge clk_i);
    #1;
    rst_n = 1'b1;

    // idle outputs before any request
    repeat (5)
    begin
      @(negedge clk_i);
      compare_hex("s_axis_tx_tvalid_o", s_axis_tx_tvalid_o, 0);
      compare_hex("s_axis_tx_tlast_o", s_axis_tx_tlast_o, 0);
      compare_hex("cfg_interrupt_o", cfg_interrupt_o, 0);
      compare_hex("wr_fifo_pop_o", wr_fifo_pop_o, 0);
      compare_hex("intr_done_o", intr_done_o, 0);
    end
    @(posedge clk_i);
    #1;

    send_completion(3'd2, 1'b0, 1'b1, 2'b01, 10'd1, 16'h0100, 8'h2C, 7'h34, 32'hDEAD_BEEF);
    wait_for_idle(200, "the completion");
    compare_hex("cpl_req_ready_o pulses", cpl_ready_cnt, 1);

    send_read(32'h8000_1240, 12'd256, 8'h11);
    wait_for_idle(200, "the read request");
    compare_hex("rd_req_ready_o pulses", rd_ready_cnt, 1);

    // two bursts from one address load
    wr_base_addr_i = 32'h4000_0F80;
    wr_addr_load_i = 1'b1;
    @(posedge clk_i);
    #1;
    wr_addr_load_i = 1'b0;
    expect_write_burst(32'h4000_0F80, 0);
    expect_write_burst(32'h4000_1000, 16);
    wr_enable = 1'b1;
    wait_for_idle(1000, "the write bursts");
    compare_hex("wr_fifo_pop_o pulses", pop_cnt, 32);
    check_true(stall_cnt > 0, "tready never held back a beat");

    // all three sources at once
    rand_ready = 1'b0;
    repeat (2) @(posedge clk_i);
    #1;
    send_completion(3'd0, 1'b1, 1'b0, 2'b10, 10'd1, 16'h0200, 8'h07, 7'h08, 32'h0123_4567);
    send_read(32'h0000_2000, 12'd64, 8'h42);
    intr_req_i = 1'b1;
    wait_for_idle(200, "the completion and read request");
    wait_intr_handshake(200);
    repeat (5) @(posedge clk_i);
    compare_hex("cpl_req_ready_o pulses", cpl_ready_cnt, 2);
    compare_hex("rd_req_ready_o pulses", rd_ready_cnt, 2);
    compare_hex("intr_done_o pulses", intr_done_cnt, 1);

    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

// File: pcie_tx.f
rtl/tx_cfg_pkg.sv
rtl/tlp_pkg.sv
rtl/tx_arbiter.sv
rtl/tlp_short_gen.sv
rtl/wr_burst_packer.sv
rtl/intr_sender.sv
rtl/tx_out_stage.sv
rtl/pcie_tx_top.sv
sim/pcie_tx_tb.sv

// File: Bender.yml
package:
  name: pcie_tx

sources:
  - files:
      - rtl/tx_cfg_pkg.sv
      - rtl/tlp_pkg.sv
      - rtl/tx_arbiter.sv
      - rtl/tlp_short_gen.sv
      - rtl/wr_burst_packer.sv
      - rtl/intr_sender.sv
      - rtl/tx_out_stage.sv
      - rtl/pcie_tx_top.sv
  - target: simulation
    files:
      - sim/pcie_tx_tb.sv
